// ==== source/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

	localparam int XLEN = 64;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      reg_idx_t;

	localparam logic [6:0] OP_IMM    = 7'h13;
	localparam logic [6:0] OP_REG    = 7'h33;
	localparam logic [6:0] OP_LUI    = 7'h37;
	localparam logic [6:0] OP_JAL    = 7'h6f;
	localparam logic [6:0] OP_JALR   = 7'h67;
	localparam logic [6:0] OP_BRANCH = 7'h63;
	localparam logic [6:0] OP_TRAP   = 7'h6b; // halt, code in a0

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} instr_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_PASS_B, ALU_EQ, ALU_NE} alu_op_t;
	typedef enum logic {SRC_A_REG, SRC_A_PC} src_a_t;
	typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} src_b_t;
	typedef enum logic [1:0] {FLOW_SEQ, FLOW_BRANCH, FLOW_JAL, FLOW_JALR} flow_t;

	typedef struct packed {
		alu_op_t alu_op;
		src_a_t  src_a;
		src_b_t  src_b;
		flow_t   flow;
		logic    reg_wen;
		logic    trap;
	} decode_ctrl_t;

	typedef struct packed {
		logic  valid;
		xlen_t addr;
	} fetch_req_t;

	typedef struct packed {
		logic   valid;
		instr_t data;
	} fetch_rsp_t;

	typedef struct packed {
		logic     valid;
		xlen_t    pc;
		instr_t   instr;
		logic     wen;
		reg_idx_t wdest;
		xlen_t    wdata;
	} commit_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] code;
		xlen_t      cycle_cnt;
		xlen_t      instr_cnt;
	} trap_t;

endpackage

`default_nettype wire

// ==== source/core_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_control import rv_core_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         fetch_ready,
	input  fetch_rsp_t   fetch_rsp,
	input  decode_ctrl_t ctrl,
	input  xlen_t        pc,
	output fetch_req_t   fetch_req,
	output instr_t       instr,
	output logic         retire,
	output logic         reg_we,
	output logic         halt_now
);

	typedef enum logic [1:0] {FETCH_REQ, FETCH_WAIT, EXECUTE, HALT} state_t;

	state_t state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH_REQ;
		end else begin
			case (state)
				FETCH_REQ: if (fetch_ready) state <= FETCH_WAIT;
				FETCH_WAIT: if (fetch_rsp.valid) state <= EXECUTE;
				EXECUTE: state <= ctrl.trap ? HALT : FETCH_REQ;
				default: state <= HALT; // stays halted
			endcase
		end
	end

	// instruction register
	always_ff @(posedge clock) begin
		if (state == FETCH_WAIT && fetch_rsp.valid) begin
			instr <= fetch_rsp.data;
		end
	end

	assign fetch_req = '{valid: (state == FETCH_REQ), addr: pc}; // addr held by pc_unit
	assign retire    = (state == EXECUTE);
	assign reg_we    = retire && ctrl.reg_wen;
	assign halt_now  = retire && ctrl.trap;

endmodule

`default_nettype wire

// ==== source/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit import rv_core_pkg::*; #(
	parameter xlen_t reset_pc = 64'h8000_0000
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         retire,
	input  decode_ctrl_t ctrl,
	input  xlen_t        imm,
	input  xlen_t        rs1_data,
	input  logic         taken,
	output xlen_t        pc
);

	xlen_t pc_next;
	xlen_t jalr_sum;

	assign jalr_sum = rs1_data + imm;

	always_comb begin
		case (ctrl.flow)
			FLOW_JAL:    pc_next = pc + imm;
			FLOW_BRANCH: pc_next = taken ? pc + imm : pc + 64'd4;
			FLOW_JALR:   pc_next = {jalr_sum[XLEN-1:1], 1'b0}; // lsb dropped
			default:     pc_next = pc + 64'd4;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (retire) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rv_core_pkg::*; (
	input  instr_t       instr,
	output decode_ctrl_t ctrl,
	output xlen_t        imm,
	output reg_idx_t     rs1,
	output reg_idx_t     rs2,
	output reg_idx_t     rd
);

	xlen_t imm_i;
	xlen_t imm_b;
	xlen_t imm_u;
	xlen_t imm_j;

	// register fields sit at the same bits in every format
	assign rs1 = instr.r_fmt.rs1;
	assign rs2 = instr.r_fmt.rs2;
	assign rd  = instr.r_fmt.rd;

	assign imm_i = {{52{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
	assign imm_b = {{51{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
		instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
	assign imm_u = {{32{instr.u_fmt.imm[19]}}, instr.u_fmt.imm, 12'h000};
	assign imm_j = {{43{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
		instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

	always_comb begin
		ctrl = '{alu_op: ALU_ADD, src_a: SRC_A_REG, src_b: SRC_B_REG,
			flow: FLOW_SEQ, reg_wen: 1'b0, trap: 1'b0}; // no-op default
		imm  = imm_i;
		case (instr.r_fmt.opcode)
			OP_IMM: begin
				ctrl.src_b   = SRC_B_IMM;
				ctrl.reg_wen = 1'b1;
			end
			OP_REG: begin
				ctrl.alu_op  = instr.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
				ctrl.reg_wen = 1'b1;
			end
			OP_LUI: begin
				ctrl.alu_op  = ALU_PASS_B;
				ctrl.src_b   = SRC_B_IMM;
				ctrl.reg_wen = 1'b1;
				imm          = imm_u;
			end
			OP_JAL, OP_JALR: begin
				ctrl.src_a   = SRC_A_PC; // link value pc + 4
				ctrl.src_b   = SRC_B_FOUR;
				ctrl.flow    = (instr.r_fmt.opcode == OP_JAL) ? FLOW_JAL : FLOW_JALR;
				ctrl.reg_wen = 1'b1;
				imm          = (instr.r_fmt.opcode == OP_JAL) ? imm_j : imm_i;
			end
			OP_BRANCH: begin
				ctrl.alu_op = instr.b_fmt.funct3[0] ? ALU_NE : ALU_EQ;
				ctrl.flow   = FLOW_BRANCH;
				imm         = imm_b;
			end
			OP_TRAP: ctrl.trap = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  logic     we,
	input  xlen_t    wdata,
	output xlen_t    rs1_data,
	output xlen_t    rs2_data,
	output xlen_t    a0_data
);

	xlen_t regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin // x0 stays zero
			regs[rd] <= wdata;
		end
	end

	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];
	assign a0_data  = regs[10];

endmodule

`default_nettype wire

// ==== source/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit import rv_core_pkg::*; (
	input  decode_ctrl_t ctrl,
	input  xlen_t        rs1_data,
	input  xlen_t        rs2_data,
	input  xlen_t        imm,
	input  xlen_t        pc,
	output xlen_t        result,
	output logic         taken
);

	xlen_t op_a;
	xlen_t op_b;

	assign op_a = (ctrl.src_a == SRC_A_PC) ? pc : rs1_data;

	always_comb begin
		case (ctrl.src_b)
			SRC_B_IMM:  op_b = imm;
			SRC_B_FOUR: op_b = 64'd4;
			default:    op_b = rs2_data;
		endcase
	end

	assign taken = (ctrl.alu_op == ALU_EQ && op_a == op_b)
		|| (ctrl.alu_op == ALU_NE && op_a != op_b);

	always_comb begin
		case (ctrl.alu_op)
			ALU_SUB:        result = op_a - op_b;
			ALU_PASS_B:     result = op_b; // lui
			ALU_EQ, ALU_NE: result = {63'd0, taken};
			default:        result = op_a + op_b;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/commit_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_monitor import rv_core_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     retire,
	input  logic     halt_now,
	input  xlen_t    pc,
	input  instr_t   instr,
	input  logic     reg_we,
	input  reg_idx_t rd,
	input  xlen_t    result,
	input  xlen_t    a0_data,
	output commit_t  commit,
	output trap_t    trap
);

	logic       commit_valid;
	xlen_t      c_pc;
	instr_t     c_instr;
	logic       c_wen;
	reg_idx_t   c_wdest;
	xlen_t      c_wdata;
	logic       trap_valid;
	logic [7:0] trap_code;
	xlen_t      cycle_cnt;
	xlen_t      instr_cnt;

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid <= 1'b0;
			trap_valid   <= 1'b0;
			trap_code    <= 8'h00;
			cycle_cnt    <= '0;
			instr_cnt    <= '0;
		end else begin
			commit_valid <= retire; // one cycle pulse
			if (!trap_valid) cycle_cnt <= cycle_cnt + 64'd1; // frozen once halted
			if (retire) instr_cnt <= instr_cnt + 64'd1;
			if (halt_now) begin
				trap_valid <= 1'b1;
				trap_code  <= a0_data[7:0];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (retire) begin
			c_pc    <= pc;
			c_instr <= instr;
			c_wen   <= reg_we;
			c_wdest <= rd;
			c_wdata <= result;
		end
	end

	assign commit = '{valid: commit_valid, pc: c_pc, instr: c_instr, wen: c_wen,
		wdest: c_wdest, wdata: c_wdata};
	assign trap = '{valid: trap_valid, code: trap_code, cycle_cnt: cycle_cnt,
		instr_cnt: instr_cnt};

endmodule

`default_nettype wire

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
	parameter xlen_t reset_pc = 64'h8000_0000
) (
	input  logic       clock,
	input  logic       reset,
	input  logic       fetch_ready,
	input  fetch_rsp_t fetch_rsp,
	output fetch_req_t fetch_req,
	output commit_t    commit,
	output trap_t      trap
);

	decode_ctrl_t ctrl;
	instr_t       instr;
	xlen_t        imm;
	xlen_t        pc;
	xlen_t        rs1_data;
	xlen_t        rs2_data;
	xlen_t        a0_data;
	xlen_t        result;
	reg_idx_t     rs1;
	reg_idx_t     rs2;
	reg_idx_t     rd;
	logic         retire;
	logic         reg_we;
	logic         halt_now;
	logic         taken;

	core_control u_control (
		.clock(clock), .reset(reset), .fetch_ready(fetch_ready), .fetch_rsp(fetch_rsp),
		.ctrl(ctrl), .pc(pc), .fetch_req(fetch_req), .instr(instr),
		.retire(retire), .reg_we(reg_we), .halt_now(halt_now)
	);

	pc_unit #(.reset_pc(reset_pc)) u_pc (
		.clock(clock), .reset(reset), .retire(retire), .ctrl(ctrl), .imm(imm),
		.rs1_data(rs1_data), .taken(taken), .pc(pc)
	);

	instr_decoder u_decoder (
		.instr(instr), .ctrl(ctrl), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd)
	);

	reg_file u_regs (
		.clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd), .we(reg_we),
		.wdata(result), .rs1_data(rs1_data), .rs2_data(rs2_data), .a0_data(a0_data)
	);

	alu_unit u_alu (
		.ctrl(ctrl), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc),
		.result(result), .taken(taken)
	);

	commit_monitor u_monitor (
		.clock(clock), .reset(reset), .retire(retire), .halt_now(halt_now), .pc(pc),
		.instr(instr), .reg_we(reg_we), .rd(rd), .result(result), .a0_data(a0_data),
		.commit(commit), .trap(trap)
	);

endmodule

`default_nettype wire

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

	localparam xlen_t start_pc = 64'h8000_0000;

	logic       clock;
	logic       reset = 1'b1;
	logic       fetch_ready = 1'b0;
	fetch_rsp_t fetch_rsp = '0;
	fetch_req_t fetch_req;
	commit_t    commit;
	trap_t      trap;

	logic [31:0] mem [64];
	logic        random_delays = 1'b0;
	logic        reset_seen = 1'b1; // reset as the DUT saw it at the last edge
	logic        req_v;
	xlen_t       req_a;
	logic        pending;
	logic        first_accept;
	xlen_t       rsp_addr;
	xlen_t       rsp_offset;
	int          rsp_wait;

	commit_t     exp_q [$];
	commit_t     run_log [$];
	commit_t     ref_log [$];
	int          cycle_idx;
	int          rsp_cycle;
	int          n_commits;
	int          trap_commit_cycle;
	int unsigned seed_value;

	rv_core_top #(.reset_pc(start_pc)) UUT (
		.clock(clock), .reset(reset), .fetch_ready(fetch_ready), .fetch_rsp(fetch_rsp),
		.fetch_req(fetch_req), .commit(commit), .trap(trap)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
		end
	endtask

	// fetch memory, request sampled at negedge and answered after the edge
	always begin
		@(negedge clock);
		req_v = fetch_req.valid;
		req_a = fetch_req.addr;
		@(posedge clock);
		reset_seen = reset;
		#1;
		fetch_rsp.valid = 1'b0;
		if (reset_seen) begin
			fetch_ready  = 1'b0;
			pending      = 1'b0;
			first_accept = 1'b1;
		end else begin
			if (fetch_ready && req_v) begin // accepted at this edge
				if (first_accept) check("first fetch_req.addr", req_a, start_pc);
				first_accept = 1'b0;
				pending      = 1'b1;
				rsp_addr     = req_a;
				rsp_wait     = random_delays ? int'($urandom % 4) : 0;
			end
			if (pending && rsp_wait == 0) begin
				rsp_offset = rsp_addr - start_pc;
				if (rsp_offset >= 64'd256) report_failure("fetch address outside the program");
				fetch_rsp.valid = 1'b1;
				fetch_rsp.data  = mem[rsp_offset[7:2]];
				pending         = 1'b0;
			end else if (pending) begin
				rsp_wait--; // response stall
			end
			fetch_ready = random_delays ? ($urandom % 3 != 0) : 1'b1;
		end
	end

	function automatic logic [31:0] itype(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, op};
	endfunction

	function automatic logic [31:0] rtype(input logic [6:0] funct7, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		return {funct7, rs2, rs1, 3'b000, rd, OP_REG};
	endfunction

	function automatic logic [31:0] utype(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	function automatic logic [31:0] btype(input logic [2:0] funct3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	task automatic clear_program();
		exp_q.delete();
		for (int i = 0; i < 64; i++) begin
			mem[i[5:0]] = {i[24:0], 7'h7f}; // unknown opcode, distinct per slot
		end
	endtask

	task automatic expect_step(input logic [5:0] idx, input logic [31:0] word, input logic wen,
		input logic [4:0] rd, input xlen_t wdata);
		mem[idx] = word;
		exp_q.push_back('{valid: 1'b1, pc: start_pc + {56'd0, idx, 2'b00}, instr: word,
			wen: wen, wdest: rd, wdata: wdata});
	endtask

	task automatic check_commit();
		commit_t e;
		if (cycle_idx != rsp_cycle + 2) begin // execute cycle sits in between
			report_failure("commit pulse not two cycles after its fetch response");
		end
		if (exp_q.size() == 0) report_failure("commit seen after the expected program ended");
		e = exp_q.pop_front();
		check("commit.pc", commit.pc, e.pc);
		check("commit.instr", {32'd0, commit.instr}, {32'd0, e.instr});
		check("commit.wen", {63'd0, commit.wen}, {63'd0, e.wen});
		if (e.wen) begin
			check("commit.wdest", {59'd0, commit.wdest}, {59'd0, e.wdest});
			check("commit.wdata", commit.wdata, e.wdata);
		end
		run_log.push_back(commit);
		n_commits++;
		if (commit.instr.r_fmt.opcode == OP_TRAP) begin
			trap_commit_cycle = cycle_idx;
			check("trap.valid", {63'd0, trap.valid}, 64'd1); // same cycle as the commit
		end
	endtask

	// one cycle of output observation at the negedge
	task automatic watch_cycle();
		@(negedge clock);
		if (reset) begin
			cycle_idx = 0;
			rsp_cycle = -8;
		end else begin
			cycle_idx++;
		end
		if (reset_seen && (commit.valid !== 1'b0 || trap.valid !== 1'b0)) begin
			report_failure("commit or trap valid while the core is in reset");
		end
		if (!reset) begin
			if (fetch_rsp.valid) rsp_cycle = cycle_idx;
			if (trap.valid && fetch_req.valid) report_failure("fetch request issued after the trap");
			if (commit.valid) check_commit();
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#1 reset = 1'b1;
		repeat (16) begin
			watch_cycle();
			@(posedge clock);
		end
		#1 reset = 1'b0;
	endtask

	task automatic run_program(input logic delays);
		int waited;
		random_delays = delays;
		run_log.delete();
		n_commits = 0;
		apply_reset();
		waited = 0;
		while (trap.valid !== 1'b1) begin
			watch_cycle();
			waited++;
			if (waited > 3000) report_failure("timed out waiting for trap.valid");
		end
		repeat (8) watch_cycle(); // core must stay quiet once halted
		check("expected commits left", 64'(exp_q.size()), 64'd0);
		check("trap.instr_cnt", trap.instr_cnt, 64'(n_commits));
		// commit pulse lands one cycle after the trap's EXECUTE
		check("trap.cycle_cnt", trap.cycle_cnt, 64'(trap_commit_cycle - 1));
	endtask

	task automatic arithmetic_test();
		clear_program();
		expect_step(6'd0, itype(OP_IMM, 5'd1, 5'd0, 12'hffb), 1'b1, 5'd1, 64'(-5));
		expect_step(6'd1, itype(OP_IMM, 5'd2, 5'd0, 12'd100), 1'b1, 5'd2, 64'd100);
		expect_step(6'd2, rtype(7'h00, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 64'd95);
		expect_step(6'd3, rtype(7'h20, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, 64'(-105));
		expect_step(6'd4, utype(5'd5, 20'h80000), 1'b1, 5'd5, 64'hffff_ffff_8000_0000);
		expect_step(6'd5, utype(5'd6, 20'h12345), 1'b1, 5'd6, 64'h0000_0000_1234_5000);
		expect_step(6'd6, itype(OP_IMM, 5'd0, 5'd1, 12'd7), 1'b1, 5'd0, 64'd2); // x0 write
		expect_step(6'd7, rtype(7'h00, 5'd7, 5'd0, 5'd2), 1'b1, 5'd7, 64'd100); // x0 reads 0
		expect_step(6'd8, itype(OP_IMM, 5'd8, 5'd7, 12'hf38), 1'b1, 5'd8, 64'(-100));
		expect_step(6'd9, itype(OP_IMM, 5'd10, 5'd4, 12'h1ab), 1'b1, 5'd10, 64'h142);
		expect_step(6'd10, 32'h0000_000b, 1'b0, 5'd0, 64'd0); // unknown opcode
		expect_step(6'd11, 32'h0000_006b, 1'b0, 5'd0, 64'd0);
		run_program(1'b0);
		check("trap.code", {56'd0, trap.code}, 64'h42);
	endtask

	task automatic load_flow_program();
		clear_program();
		expect_step(6'd0, itype(OP_IMM, 5'd1, 5'd0, 12'd3), 1'b1, 5'd1, 64'd3);
		expect_step(6'd1, itype(OP_IMM, 5'd2, 5'd0, 12'd3), 1'b1, 5'd2, 64'd3);
		expect_step(6'd2, btype(3'd0, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0); // beq taken
		expect_step(6'd4, btype(3'd1, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0); // bne falls
		expect_step(6'd5, btype(3'd0, 5'd1, 5'd0, 13'd8), 1'b0, 5'd0, 64'd0); // beq falls
		expect_step(6'd6, btype(3'd1, 5'd1, 5'd0, 13'd8), 1'b0, 5'd0, 64'd0); // bne taken
		expect_step(6'd8, jtype(5'd5, 21'd12), 1'b1, 5'd5, start_pc + 64'd36);
		// odd target, bit 0 is dropped
		expect_step(6'd11, itype(OP_JALR, 5'd6, 5'd5, 12'd17), 1'b1, 5'd6, start_pc + 64'd48);
		expect_step(6'd13, rtype(7'h00, 5'd10, 5'd5, 5'd6), 1'b1, 5'd10, 64'h1_0000_0054);
		expect_step(6'd14, 32'h0000_006b, 1'b0, 5'd0, 64'd0);
	endtask

	task automatic control_flow_test();
		load_flow_program();
		run_program(1'b0);
		check("trap.code", {56'd0, trap.code}, 64'h54);
		ref_log = run_log;
	endtask

	task automatic backpressure_test();
		load_flow_program();
		run_program(1'b1);
		check("commit count", 64'(run_log.size()), 64'(ref_log.size()));
		foreach (run_log[i]) begin
			check("commit.pc", run_log[i].pc, ref_log[i].pc);
			check("commit.instr", {32'd0, run_log[i].instr}, {32'd0, ref_log[i].instr});
			check("commit.wdata", run_log[i].wdata, ref_log[i].wdata);
		end
	endtask

	initial begin
		seed_value = $urandom(32'h89874491);
		arithmetic_test();
		control_flow_test();
		backpressure_test();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/rv_core_pkg.sv
source/core_control.sv
source/pc_unit.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu_unit.sv
source/commit_monitor.sv
source/rv_core_top.sv
dv/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -f flist.f --top-module rv_core_tb -o rv_core_sim; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/rv_core_sim)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -q "Simulation PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
